// ==== logic/mem_bus_pkg.sv ====
// memory bus definitions
// command encoding and the widths of tag, address and line data
// shared by the fetch front end and the memory side

package mem_bus_pkg;

  // bus command, two bits on the wire
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_t;

  localparam int mem_tag_bits  = 4;
  localparam int addr_bits     = 64;
  localparam int line_bits     = 64;

  // zero tag means no transaction
  typedef logic [mem_tag_bits-1:0] mem_tag_t;

  // byte address
  typedef logic [addr_bits-1:0] addr_t;

  // one memory word is one cache line
  typedef logic [line_bits-1:0] line_data_t;

endpackage

// ==== logic/fetch_pkg.sv ====
// fetch definitions
// instruction cache geometry, address field positions,
// instruction width and the miss controller states

package fetch_pkg;

  ////////////////////////////////
  // cache geometry
  ////////////////////////////////
  localparam int icache_lines   = 32;
  localparam int offset_bits    = 3;            // 8 bytes per line
  localparam int index_bits     = 5;            // addr[7:3]
  localparam int cache_tag_bits = 8;            // addr[15:8], program below 64 KiB
  localparam int index_lsb      = offset_bits;
  localparam int tag_lsb        = offset_bits + index_bits;

  localparam int inst_bits      = 32;
  localparam int inst_bytes     = inst_bits / 8;

  typedef logic [index_bits-1:0]     index_t;
  typedef logic [cache_tag_bits-1:0] cache_tag_t;
  typedef logic [inst_bits-1:0]      inst_t;

  // miss state machine
  typedef enum logic [1:0] {
    IDLE      = 2'h0,
    REQUEST   = 2'h1,
    WAIT_DATA = 2'h2
  } icache_state_t;

endpackage

// ==== logic/icache_mem.sv ====
// instruction cache arrays
// direct mapped data, tag and valid storage
// combinational lookup on the fetch address, whole line write on fill

`timescale 1ns/1ps

module icache_mem (
  input  logic                   clock,
  input  logic                   reset,
  input  mem_bus_pkg::addr_t     fetch_addr,
  input  logic                   fill_en,
  input  fetch_pkg::index_t      fill_index,
  input  fetch_pkg::cache_tag_t  fill_tag,
  input  mem_bus_pkg::line_data_t fill_data,
  output mem_bus_pkg::line_data_t line_out,
  output logic                   hit
);

  import mem_bus_pkg::*;
  import fetch_pkg::*;

  line_data_t             data_mem [icache_lines];
  cache_tag_t             tag_mem  [icache_lines];
  logic [icache_lines-1:0] valid;

  index_t     rd_index;
  cache_tag_t rd_tag;

  ////////////////////////////////
  // lookup
  ////////////////////////////////
  assign rd_index = fetch_addr[index_lsb +: index_bits];
  assign rd_tag   = fetch_addr[tag_lsb +: cache_tag_bits];

  assign line_out = data_mem[rd_index];
  assign hit      = valid[rd_index] && (tag_mem[rd_index] == rd_tag);

  ////////////////////////////////
  // fill
  ////////////////////////////////
  always_ff @(posedge clock) begin
    if (fill_en) begin
      data_mem[fill_index] <= fill_data;
      tag_mem[fill_index]  <= fill_tag;
    end
  end

  // valid bits come up clear
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (fill_en) begin
      valid[fill_index] <= 1'b1;
    end
  end

endmodule

// ==== logic/icache_ctrl.sv ====
// instruction cache miss controller
// one outstanding load at a time on the tagged memory bus
// holds the request until accepted, then waits for the matching
// reply tag and writes the returned line into the cache

`timescale 1ns/1ps

module icache_ctrl (
  input  logic                  clock,
  input  logic                  reset,
  input  mem_bus_pkg::addr_t    fetch_addr,
  input  logic                  hit,
  input  mem_bus_pkg::mem_tag_t mem2proc_response,
  input  mem_bus_pkg::mem_tag_t mem2proc_tag,
  output mem_bus_pkg::bus_cmd_t proc2mem_command,
  output mem_bus_pkg::addr_t    proc2mem_addr,
  output logic                  fill_en,
  output fetch_pkg::index_t     fill_index,
  output fetch_pkg::cache_tag_t fill_tag
);

  import mem_bus_pkg::*;
  import fetch_pkg::*;

  icache_state_t state;
  icache_state_t next_state;

  addr_t    miss_addr;        // line aligned and fixed once the request starts
  mem_tag_t pending_tag;      // tag handed back on acceptance

  logic start_miss;
  logic accepted;
  logic reply_match;

  ////////////////////////////////
  // events
  ////////////////////////////////
  assign start_miss = (state == IDLE) && !hit;
  assign accepted   = (state == REQUEST) && (mem2proc_response != '0);

  // reply for our own transaction
  assign reply_match = (state == WAIT_DATA) && (mem2proc_tag == pending_tag);

  ////////////////////////////////
  // state machine
  ////////////////////////////////
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (start_miss) begin
          next_state = REQUEST;
        end
      end
      REQUEST: begin
        if (accepted) begin
          next_state = WAIT_DATA;   // rejected requests stay here
        end
      end
      WAIT_DATA: begin
        if (reply_match) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // transaction tag
  always_ff @(posedge clock) begin
    if (reset) begin
      pending_tag <= '0;
    end else if (accepted) begin
      pending_tag <= mem2proc_response;
    end
  end

  // latched miss address stays put across a redirect
  always_ff @(posedge clock) begin
    if (start_miss) begin
      miss_addr <= {fetch_addr[$bits(addr_t)-1:offset_bits], {offset_bits{1'b0}}};
    end
  end

  ////////////////////////////////
  // bus and fill outputs
  ////////////////////////////////
  assign proc2mem_command = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
  assign proc2mem_addr    = (state == REQUEST) ? miss_addr : '0;

  assign fill_en    = reply_match;                        // single cycle pulse
  assign fill_index = miss_addr[index_lsb +: index_bits];
  assign fill_tag   = miss_addr[tag_lsb +: cache_tag_bits];

endmodule

// ==== logic/fetch_pc.sv ====
// fetch program counter and IF/ID register
// advances on a cache hit when the consumer takes an instruction,
// redirects on a branch, and registers the selected instruction
// together with its next PC

`timescale 1ns/1ps

module fetch_pc (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    get_next_inst,
  input  logic                    take_branch,
  input  mem_bus_pkg::addr_t      take_branch_target,
  input  mem_bus_pkg::line_data_t line_out,
  input  logic                    hit,
  output mem_bus_pkg::addr_t      fetch_addr,
  output fetch_pkg::inst_t        if_id_inst,
  output mem_bus_pkg::addr_t      if_id_npc,
  output logic                    if_id_valid
);

  import mem_bus_pkg::*;
  import fetch_pkg::*;

  addr_t pc;
  addr_t pc_plus_4;
  addr_t next_pc;
  inst_t cur_inst;
  logic  advance;

  assign pc_plus_4 = pc + addr_t'(inst_bytes);

  // branch wins over a sequential step
  assign advance = get_next_inst && hit && !take_branch;

  always_comb begin
    next_pc = pc;
    if (take_branch) begin
      next_pc = take_branch_target;
    end else if (advance) begin
      next_pc = pc_plus_4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  assign fetch_addr = pc;

  // pc bit 2 picks the half of the line
  assign cur_inst = pc[2] ? line_out[2*inst_bits-1:inst_bits] : line_out[inst_bits-1:0];

  ////////////////////////////////
  // IF/ID register
  ////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      if_id_valid <= 1'b0;
    end else begin
      if_id_valid <= advance;     // low on stall, miss or redirect
    end
  end

  always_ff @(posedge clock) begin
    if_id_inst <= cur_inst;
    if_id_npc  <= pc_plus_4;
  end

endmodule

// ==== logic/fetch_frontend.sv ====
// instruction fetch front end
// program counter, direct mapped instruction cache and its miss
// controller on a tagged memory bus, feeding the IF/ID register

`timescale 1ns/1ps

module fetch_frontend (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    get_next_inst,
  input  logic                    take_branch,
  input  mem_bus_pkg::addr_t      take_branch_target,
  input  mem_bus_pkg::mem_tag_t   mem2proc_response,
  input  mem_bus_pkg::line_data_t mem2proc_data,
  input  mem_bus_pkg::mem_tag_t   mem2proc_tag,
  output mem_bus_pkg::bus_cmd_t   proc2mem_command,
  output mem_bus_pkg::addr_t      proc2mem_addr,
  output fetch_pkg::inst_t        if_id_inst,
  output mem_bus_pkg::addr_t      if_id_npc,
  output logic                    if_id_valid
);

  import mem_bus_pkg::*;
  import fetch_pkg::*;

  addr_t      fetch_addr;
  line_data_t line_out;
  logic       hit;

  // fill path from the controller
  logic       fill_en;
  index_t     fill_index;
  cache_tag_t fill_tag;

  ////////////////////////////////
  // program counter and IF/ID
  ////////////////////////////////
  fetch_pc fetch_pc_inst (
    .clock              (clock),
    .reset              (reset),
    .get_next_inst      (get_next_inst),
    .take_branch        (take_branch),
    .take_branch_target (take_branch_target),
    .line_out           (line_out),
    .hit                (hit),
    .fetch_addr         (fetch_addr),
    .if_id_inst         (if_id_inst),
    .if_id_npc          (if_id_npc),
    .if_id_valid        (if_id_valid)
  );

  ////////////////////////////////
  // miss controller
  ////////////////////////////////
  icache_ctrl icache_ctrl_inst (
    .clock             (clock),
    .reset             (reset),
    .fetch_addr        (fetch_addr),
    .hit               (hit),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .fill_en           (fill_en),
    .fill_index        (fill_index),
    .fill_tag          (fill_tag)
  );

  // line data comes straight off the bus
  icache_mem icache_mem_inst (
    .clock      (clock),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .fill_en    (fill_en),
    .fill_index (fill_index),
    .fill_tag   (fill_tag),
    .fill_data  (mem2proc_data),
    .line_out   (line_out),
    .hit        (hit)
  );

endmodule

// ==== testbench/mem_model_tb.sv ====
// tagged memory model for the fetch front end
// accepts about three loads in four, answers three cycles later
// with a line built from the address pattern

`timescale 1ns/1ps

module mem_model_tb (
  input  logic                    clock,
  input  logic                    reset,
  input  mem_bus_pkg::bus_cmd_t   proc2mem_command,
  input  mem_bus_pkg::addr_t      proc2mem_addr,
  output mem_bus_pkg::mem_tag_t   mem2proc_response,
  output mem_bus_pkg::line_data_t mem2proc_data,
  output mem_bus_pkg::mem_tag_t   mem2proc_tag,
  output int                      load_count,
  output int                      reject_count,
  output logic                    busy
);

  import mem_bus_pkg::*;

  localparam int reply_latency = 3;

  integer   seed        = 32'h43d27543;
  logic     accept_roll = 1'b0;         // accept decision for this cycle
  mem_tag_t next_tag    = 4'h1;         // rolling, never zero
  logic     accept_now;

  logic [reply_latency-1:0] stage_valid = '0;
  mem_tag_t                 stage_tag  [reply_latency];
  addr_t                    stage_addr [reply_latency];

  // instruction stored at byte address p
  function automatic logic [31:0] inst_word(input addr_t p);
    return p[31:0] ^ 32'hA5A5_0000;
  endfunction

  function automatic line_data_t line_word(input addr_t a);
    addr_t base;
    base = {a[63:3], 3'b000};
    return {inst_word(base + 64'd4), inst_word(base)};
  endfunction

  initial begin
    load_count   = 0;
    reject_count = 0;
    for (int i = 0; i < reply_latency; i++) begin
      stage_tag[i]  = '0;
      stage_addr[i] = '0;
    end
  end

  ////////////////////////////////
  // request side
  ////////////////////////////////
  assign accept_now        = (proc2mem_command === BUS_LOAD) && accept_roll;
  assign mem2proc_response = accept_now ? next_tag : '0;

  always @(posedge clock) begin
    accept_roll <= ($random(seed) & 32'h3) != 0;   // roughly one in four rejected
    if (reset) begin
      stage_valid  <= '0;
      next_tag     <= 4'h1;
      load_count   <= 0;
      reject_count <= 0;
    end else begin
      stage_valid   <= {stage_valid[reply_latency-2:0], accept_now};
      stage_tag[0]  <= mem2proc_response;
      stage_addr[0] <= proc2mem_addr;
      for (int i = 1; i < reply_latency; i++) begin
        stage_tag[i]  <= stage_tag[i-1];
        stage_addr[i] <= stage_addr[i-1];
      end
      if (accept_now) begin
        load_count <= load_count + 1;
        next_tag   <= (next_tag == 4'hF) ? 4'h1 : next_tag + 4'h1;
      end else if (proc2mem_command === BUS_LOAD) begin
        reject_count <= reject_count + 1;    // same request comes back next cycle
      end
    end
  end

  ////////////////////////////////
  // reply side
  ////////////////////////////////
  assign mem2proc_tag  = stage_valid[reply_latency-1] ? stage_tag[reply_latency-1] : '0;
  assign mem2proc_data = stage_valid[reply_latency-1] ?
                         line_word(stage_addr[reply_latency-1]) : '0;
  assign busy          = |stage_valid;

endmodule

// ==== testbench/fetch_frontend_tb.sv ====
// testbench for the fetch front end
// directed tests for reset, sequential fetch, hits on re-fetch,
// eviction, stall and a redirect while a miss is pending

`timescale 1ns/1ps

module fetch_frontend_tb;

  import mem_bus_pkg::*;
  import fetch_pkg::*;

  localparam time clock_period = 40;
  localparam time drive_delay  = 1;
  localparam int  reset_cycles = 4;
  // under 100 fetches and 20 misses of well below 40 cycles each
  localparam int  timeout_cycles = 4000;

  logic       clock;
  logic       reset;
  logic       get_next_inst;
  logic       take_branch;
  addr_t      take_branch_target;
  mem_tag_t   mem2proc_response;
  line_data_t mem2proc_data;
  mem_tag_t   mem2proc_tag;
  bus_cmd_t   proc2mem_command;
  addr_t      proc2mem_addr;
  inst_t      if_id_inst;
  addr_t      if_id_npc;
  logic       if_id_valid;

  int   load_count;
  int   reject_count;
  logic mem_busy;

  addr_t expected_pc = '0;    // pc of the next valid output
  int    fetch_count = 0;
  int    cycle_count = 0;

  logic  rejected_last = 1'b0;   // load refused in the previous cycle
  addr_t rejected_addr = '0;

  fetch_frontend fetch_frontend_inst (
    .clock              (clock),
    .reset              (reset),
    .get_next_inst      (get_next_inst),
    .take_branch        (take_branch),
    .take_branch_target (take_branch_target),
    .mem2proc_response  (mem2proc_response),
    .mem2proc_data      (mem2proc_data),
    .mem2proc_tag       (mem2proc_tag),
    .proc2mem_command   (proc2mem_command),
    .proc2mem_addr      (proc2mem_addr),
    .if_id_inst         (if_id_inst),
    .if_id_npc          (if_id_npc),
    .if_id_valid        (if_id_valid)
  );

  mem_model_tb mem_model_inst (
    .clock             (clock),
    .reset             (reset),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .load_count        (load_count),
    .reject_count      (reject_count),
    .busy              (mem_busy)
  );

  always #(clock_period / 2) clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_cycles) begin
      $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped by timeout");
    end
  end

  ////////////////////////////////
  // checking
  ////////////////////////////////
  function automatic inst_t expected_inst(input addr_t p);
    return p[31:0] ^ 32'hA5A5_0000;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // bus rules and program order of the outputs
  always @(negedge clock) begin
    if (reset === 1'b0) begin
      if (proc2mem_command == BUS_STORE) begin
        check_value("proc2mem_command", proc2mem_command, BUS_LOAD);
      end
      if (proc2mem_command == BUS_LOAD) begin
        check_value("proc2mem_addr[2:0]", proc2mem_addr[2:0], 3'b000);  // line aligned
      end
      // a refused load comes back unchanged
      if (rejected_last) begin
        check_value("proc2mem_command", proc2mem_command, BUS_LOAD);
        check_value("proc2mem_addr", proc2mem_addr, rejected_addr);
      end
      rejected_last = (proc2mem_command == BUS_LOAD) && (mem2proc_response == '0);
      rejected_addr = proc2mem_addr;
      // every valid output must be the next pc in program order
      if (if_id_valid === 1'b1) begin
        check_value("if_id_npc", if_id_npc, expected_pc + 64'd4);
        check_value("if_id_inst", if_id_inst, expected_inst(expected_pc));
        expected_pc = expected_pc + 64'd4;
        fetch_count = fetch_count + 1;
      end
    end
  end

  ////////////////////////////////
  // stimulus helpers
  ////////////////////////////////
  task automatic start_fetch();
    @(posedge clock);
    #drive_delay;
    get_next_inst = 1'b1;
  endtask

  task automatic stop_fetch();
    @(posedge clock);
    #drive_delay;
    get_next_inst = 1'b0;
  endtask

  task automatic branch_to(input addr_t target);
    @(posedge clock);
    #drive_delay;
    take_branch        = 1'b1;
    take_branch_target = target;
    @(posedge clock);
    #drive_delay;
    take_branch = 1'b0;
    expected_pc = target;     // old path outputs are already checked
  endtask

  task automatic wait_fetches(input int n);
    int target;
    target = fetch_count + n;
    wait (fetch_count >= target);
  endtask

  // no request on the bus and no reply due for three cycles in a row
  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while (quiet < 3) begin
      @(negedge clock);
      if (proc2mem_command == BUS_NONE && !mem_busy) begin
        quiet = quiet + 1;
      end else begin
        quiet = 0;
      end
    end
  endtask

  task automatic wait_load_request();
    @(negedge clock);
    while (proc2mem_command != BUS_LOAD) begin
      @(negedge clock);
    end
  endtask

  task automatic jump_and_fetch(input addr_t target, input int fetches, input int new_loads);
    int loads_before;
    stop_fetch();
    wait_quiet();
    loads_before = load_count;
    branch_to(target);
    start_fetch();
    wait_fetches(fetches);
    check_value("load_count", load_count, loads_before + new_loads);
  endtask

  ////////////////////////////////
  // tests
  ////////////////////////////////
  task automatic check_reset_state();
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clock);
      if (i == reset_cycles - 1) begin
        #drive_delay;
        reset = 1'b0;
      end
      @(negedge clock);
      check_value("proc2mem_command", proc2mem_command, BUS_NONE);
      check_value("if_id_valid", if_id_valid, 1'b0);
    end
  endtask

  task automatic fetch_from_zero();
    int loads_before;
    loads_before = load_count;
    start_fetch();
    wait_fetches(16);
    check_value("load_count", load_count, loads_before + 8);   // one per line
  endtask

  task automatic refetch_hits();
    jump_and_fetch(64'h0, 16, 0);
  endtask

  // 0x100 shares index 0 with address 0
  task automatic evict_line_zero();
    jump_and_fetch(64'h0100, 1, 1);
    jump_and_fetch(64'h0000, 1, 1);
  endtask

  task automatic stall_and_resume();
    stop_fetch();
    @(posedge clock);
    repeat (10) begin
      @(negedge clock);
      check_value("if_id_valid", if_id_valid, 1'b0);
    end
    start_fetch();
    wait_fetches(4);          // monitor catches a skipped pc
  endtask

  task automatic redirect_during_miss();
    int loads_before;
    int fetches_before;
    stop_fetch();
    wait_quiet();
    loads_before   = load_count;
    fetches_before = fetch_count;
    branch_to(64'h0800);
    start_fetch();
    wait_load_request();
    branch_to(64'h0400);      // 0x800 path abandoned
    check_value("fetch_count", fetch_count, fetches_before);
    wait_fetches(1);
    check_value("load_count", load_count, loads_before + 2);
    wait_fetches(3);
  endtask

  initial begin
    clock              = 1'b0;
    reset              = 1'b1;
    get_next_inst      = 1'b0;
    take_branch        = 1'b0;
    take_branch_target = '0;

    check_reset_state();
    fetch_from_zero();
    refetch_hits();
    evict_line_zero();
    stall_and_resume();
    redirect_during_miss();

    check_value("reject_count nonzero", reject_count > 0, 1'b1);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== fetch_frontend.f ====
logic/mem_bus_pkg.sv
logic/fetch_pkg.sv
logic/icache_mem.sv
logic/icache_ctrl.sv
logic/fetch_pc.sv
logic/fetch_frontend.sv
testbench/mem_model_tb.sv
testbench/fetch_frontend_tb.sv
